//--- Bender.yml
package:
  name: hazard_pipe

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv_isa_pkg.sv
      - hdl/pipe_ctrl_pkg.sv
      - hdl/pipe_reg.sv
      - hdl/regfile.sv
      - hdl/forward_stall.sv
      - hdl/exe_unit.sv
      - hdl/lsu_unit.sv
      - hdl/hazard_pipe_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/hazard_pipe_tb.sv

//--- bench/hazard_patterns.txt
// Word 0: instruction count. Then one instruction per line: op rs1 rs2 rd (one hex digit each), imm (8 digits)
// op 0 ADD, 1 LOAD, 2 BRANCH. After the instructions: expected final values of x0 to x15
00000010
000100000005
011200000003
021300000010
130400000100
041500000001
211000000000
000600000077
212000000000
012000000007
001700000000
150800000020
180900000004
271000000000
100a00000000
097b00001000
0bbc00000000
00000000
00000005
0000000d
00000022
fffffedd
fffffee3
00000000
00000005
000000fc
fffffeff
00000000
00000f04
00001e08
00000000
00000000
00000000

//--- bench/hazard_pipe_tb.sv
// Self-checking testbench for the hazard pipeline, runs the instruction stream of the pattern file
`timescale 1ns/1ps
`include "core_defines.svh"

module hazard_pipe_tb import rv_isa_pkg::*; ();

    localparam int STALL_LIMIT = 40;
    localparam int DRAIN_LIMIT = 200;
    localparam int PAT_DEPTH   = 64;

    logic        clk;
    logic        rst_n;
    logic        instr_valid_i;
    op_e         instr_op_i;
    reg_addr_t   instr_rs1_i;
    reg_addr_t   instr_rs2_i;
    reg_addr_t   instr_rd_i;
    word_t       instr_imm_i;
    logic        instr_ready_o;
    logic        ld_req_o;
    word_t       ld_addr_o;
    logic        ld_ack_i;
    word_t       ld_data_i;
    logic        wb_valid_o;
    reg_addr_t   wb_rd_o;
    word_t       wb_data_o;
    logic        branch_taken_o;

    // Word 0 is the count, then instructions, then expected registers
    logic [47:0] pat_mem [PAT_DEPTH];
    logic [47:0] cur_word;
    int          n_instr;
    // Accepted instructions so far, also the next stream index
    int          idx;
    // Architectural model and the register state seen on the writeback port
    word_t       model_regs [`CORE_NREGS];
    word_t       seen_regs [`CORE_NREGS];
    reg_addr_t   exp_rd_q [$];
    word_t       exp_data_q [$];
    int          br_pos_q [$];
    bit          squash_next;
    int          wb_pushed;
    int          wb_seen;
    int          value_errs;
    int          other_errs;
    // Load bus responder state
    logic [31:0] rng_state;
    int          ack_wait;
    bit          ld_pending;
    logic        addr_hold;
    word_t       prev_addr;

    hazard_pipe_top dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_valid_i  (instr_valid_i),
        .instr_op_i     (instr_op_i),
        .instr_rs1_i    (instr_rs1_i),
        .instr_rs2_i    (instr_rs2_i),
        .instr_rd_i     (instr_rd_i),
        .instr_imm_i    (instr_imm_i),
        .instr_ready_o  (instr_ready_o),
        .ld_req_o       (ld_req_o),
        .ld_addr_o      (ld_addr_o),
        .ld_ack_i       (ld_ack_i),
        .ld_data_i      (ld_data_i),
        .wb_valid_o     (wb_valid_o),
        .wb_rd_o        (wb_rd_o),
        .wb_data_o      (wb_data_o),
        .branch_taken_o (branch_taken_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    ////////////////////
    // Helpers
    ////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            value_errs++;
        end
    endtask

    // Past the end of the stream, ADD x0, x0, x0, 0 keeps valid high
    task automatic drive_instr(input int pos);
        if (pos < n_instr) begin
            cur_word = pat_mem[pos + 1];
        end else begin
            cur_word = '0;
        end
        instr_valid_i = 1'b1;
        instr_op_i    = op_e'(cur_word[45:44]);
        instr_rs1_i   = cur_word[43:40];
        instr_rs2_i   = cur_word[39:36];
        instr_rd_i    = cur_word[35:32];
        instr_imm_i   = cur_word[31:0];
    endtask

    // In-order model, a taken branch kills the next accepted instruction
    task automatic model_step(input logic [47:0] w);
        op_e       op;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     res;
        op  = op_e'(w[45:44]);
        rs1 = w[43:40];
        rs2 = w[39:36];
        rd  = w[35:32];
        if (squash_next) begin
            squash_next = 1'b0;
        end else if (op == OP_BRANCH) begin
            // Pulse comes in execute, once the next instruction is accepted
            if (model_regs[rs1] == model_regs[rs2]) begin
                br_pos_q.push_back(idx + 2);
                squash_next = 1'b1;
            end
        end else begin
            // Responder returns the inverted address
            if (op == OP_LOAD) begin
                res = ~(model_regs[rs1] + w[31:0]);
            end else begin
                res = model_regs[rs1] + model_regs[rs2] + w[31:0];
            end
            exp_rd_q.push_back(rd);
            exp_data_q.push_back(res);
            wb_pushed++;
            if (rd != '0) begin
                model_regs[rd] = res;
            end
        end
    endtask

    ////////////////////
    // Load bus responder
    ////////////////////

    // Ack after 0 to 3 cycles, data is the inverted address
    initial begin
        forever begin
            @(posedge clk);
            #2;
            if (!rst_n) begin
                ld_pending = 1'b0;
                ld_ack_i   = 1'b0;
            end else begin
                // An ack seen at this edge closed the handshake
                if (ld_ack_i) begin
                    ld_ack_i   = 1'b0;
                    ld_pending = 1'b0;
                end
                if (!ld_pending && ld_req_o) begin
                    rng_state  = xorshift32(rng_state);
                    ack_wait   = rng_state % 4;
                    ld_pending = 1'b1;
                end
                if (ld_pending) begin
                    if (ack_wait == 0) begin
                        ld_ack_i  = 1'b1;
                        ld_data_i = ~ld_addr_o;
                    end else begin
                        ack_wait--;
                    end
                end
            end
        end
    end

    ////////////////////
    // Monitor
    ////////////////////

    // Mid-cycle sampling, all outputs settled
    always @(negedge clk) begin
        if (rst_n) begin
            // Pending request keeps its address and blocks issue
            if (addr_hold) begin
                if (!ld_req_o) begin
                    $display("ERROR at %0t ns: load request dropped before its ack", $time);
                    other_errs++;
                end
                check_value("ld_addr_o", ld_addr_o, prev_addr);
            end
            addr_hold = ld_req_o && !ld_ack_i;
            prev_addr = ld_addr_o;
            if (addr_hold) begin
                check_value("instr_ready_o", instr_ready_o, 1'b0);
            end
            if (wb_valid_o) begin
                if (exp_rd_q.size() == 0) begin
                    $display("ERROR at %0t ns: writeback with no instruction in flight", $time);
                    other_errs++;
                end else begin
                    check_value("wb_rd_o", wb_rd_o, exp_rd_q.pop_front());
                    check_value("wb_data_o", wb_data_o, exp_data_q.pop_front());
                end
                if (wb_rd_o != '0) begin
                    seen_regs[wb_rd_o] = wb_data_o;
                end
                wb_seen++;
            end
            // Pulse must line up with the oldest taken branch
            if (branch_taken_o) begin
                if (br_pos_q.size() == 0) begin
                    $display("ERROR at %0t ns: branch pulse with no taken branch", $time);
                    other_errs++;
                end else begin
                    check_value("accepted count at branch_taken_o", idx,
                                br_pos_q.pop_front());
                end
            end
        end
    end

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        int stall_cnt;
        int drain_cnt;
        int wb_target;
        bit take;
        bit abort;
        rst_n         = 1'b0;
        instr_valid_i = 1'b0;
        instr_op_i    = OP_ADD;
        instr_rs1_i   = '0;
        instr_rs2_i   = '0;
        instr_rd_i    = '0;
        instr_imm_i   = '0;
        ld_ack_i      = 1'b0;
        ld_data_i     = '0;
        squash_next   = 1'b0;
        wb_pushed     = 0;
        wb_seen       = 0;
        value_errs    = 0;
        other_errs    = 0;
        rng_state     = 32'd29273;
        ack_wait      = 0;
        ld_pending    = 1'b0;
        addr_hold     = 1'b0;
        prev_addr     = '0;
        cur_word      = '0;
        idx           = 0;
        abort         = 1'b0;
        for (int i = 0; i < `CORE_NREGS; i++) begin
            model_regs[i] = '0;
            seen_regs[i]  = '0;
        end
        $readmemh("bench/hazard_patterns.txt", pat_mem);
        n_instr = pat_mem[0][31:0];
        if (n_instr <= 0 || n_instr + `CORE_NREGS + 1 > PAT_DEPTH) begin
            $display("ERROR: pattern file is missing or has a bad instruction count");
            other_errs++;
            abort = 1'b1;
        end

        // Four edges in reset, idle outputs checked on the last one
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_value("instr_ready_o", instr_ready_o, 1'b1);
        check_value("ld_req_o", ld_req_o, 1'b0);
        check_value("wb_valid_o", wb_valid_o, 1'b0);
        check_value("branch_taken_o", branch_taken_o, 1'b0);
        @(posedge clk);
        #2;
        rst_n = 1'b1;

        // Issue until every pattern writeback has been seen
        idx       = 0;
        stall_cnt = 0;
        drain_cnt = 0;
        wb_target = -1;
        while (!abort && (idx < n_instr || wb_seen < wb_target)) begin
            drive_instr(idx);
            @(negedge clk);
            take = instr_ready_o;
            @(posedge clk);
            if (take) begin
                model_step(cur_word);
                idx++;
                stall_cnt = 0;
                if (idx == n_instr) begin
                    wb_target = wb_pushed;
                end
            end else begin
                stall_cnt++;
            end
            if (idx >= n_instr) begin
                drain_cnt++;
            end
            if (stall_cnt > STALL_LIMIT) begin
                $display("ERROR: timeout, no instruction accepted for %0d cycles", stall_cnt);
                other_errs++;
                abort = 1'b1;
            end
            if (drain_cnt > DRAIN_LIMIT) begin
                $display("ERROR: timeout, %0d of %0d writebacks seen", wb_seen, wb_target);
                other_errs++;
                abort = 1'b1;
            end
            #2;
        end

        // Final register state, from the DUT and from the model
        if (!abort) begin
            for (int i = 0; i < `CORE_NREGS; i++) begin
                check_value($sformatf("x%0d", i), seen_regs[i], pat_mem[n_instr + 1 + i][31:0]);
                check_value($sformatf("model x%0d", i), model_regs[i],
                            pat_mem[n_instr + 1 + i][31:0]);
            end
            if (br_pos_q.size() > 0) begin
                $display("ERROR: a taken branch never pulsed branch_taken_o");
                other_errs++;
            end
        end

        $display("Checks done: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : hazard_pipe_tb

//--- hazard_pipe_top.f
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/pipe_ctrl_pkg.sv
hdl/pipe_reg.sv
hdl/regfile.sv
hdl/forward_stall.sv
hdl/exe_unit.sv
hdl/lsu_unit.sv
hdl/hazard_pipe_top.sv
bench/hazard_pipe_tb.sv

//--- hdl/core_defines.svh
// Core sizing and reset constants, included by the ISA package and by RTL that needs them
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

////////////////////
// Datapath
////////////////////

// Width of a data word and of every address on the load bus
`define CORE_XLEN 32

// Architectural register file, register zero included
`define CORE_NREGS 16
`define CORE_RADDR_W 4

////////////////////
// Reset values
////////////////////

// Register file contents after reset
`define CORE_REG_RST '0
// Stage valid bits after reset
`define CORE_VALID_RST 1'b0

`endif

//--- hdl/exe_unit.sv
// Execute stage datapath: operand forwarding, adder and branch compare
`timescale 1ns/1ps

module exe_unit import rv_isa_pkg::*, pipe_ctrl_pkg::*; (
    input  id2exe_s  exe_data_i,
    input  fwd_sel_e fwd_rs1_sel_i,
    input  fwd_sel_e fwd_rs2_sel_i,
    input  word_t    lsu_result_i,
    input  word_t    wrb_data_i,
    output exe2lsu_s exe_out_o,
    output logic     branch_taken_o
);

    word_t op_a;
    word_t op_b;
    word_t addend;
    word_t sum;

    // Operand source per forward select
    function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t reg_val);
        word_t val;
        case (sel)
            FWD_LSU: val = lsu_result_i;
            FWD_WRB: val = wrb_data_i;
            default: val = reg_val;
        endcase
        return val;
    endfunction

    always_comb begin
        op_a = fwd_mux(fwd_rs1_sel_i, exe_data_i.rs1_val);
        op_b = fwd_mux(fwd_rs2_sel_i, exe_data_i.rs2_val);
    end

    ////////////////////
    // Adder
    ////////////////////

    // Load address is rs1 + imm only
    assign addend = (exe_data_i.op == OP_LOAD) ? '0 : op_b;
    assign sum    = op_a + addend + exe_data_i.imm;

    // Equal operands take the branch, valid gating is in control
    assign branch_taken_o = (exe_data_i.op == OP_BRANCH) && (op_a == op_b);

    always_comb begin
        exe_out_o.op        = exe_data_i.op;
        exe_out_o.rd        = exe_data_i.rd;
        exe_out_o.rd_wr_req = exe_data_i.rd_wr_req;
        exe_out_o.result    = sum;
        exe_out_o.is_load   = (exe_data_i.op == OP_LOAD);
    end

endmodule : exe_unit

//--- hdl/forward_stall.sv
// Hazard and stall control, drives operand forwarding, stage stalls and the branch flush
`timescale 1ns/1ps

module forward_stall import rv_isa_pkg::*, pipe_ctrl_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    // Execute stage
    input  logic      exe_valid_i,
    input  reg_addr_t exe_rs1_i,
    input  reg_addr_t exe_rs2_i,
    input  logic      exe_use_rs1_i,
    input  logic      exe_use_rs2_i,
    input  logic      exe_branch_taken_i,
    // Load/store stage and load bus
    input  logic      lsu_valid_i,
    input  reg_addr_t lsu_rd_i,
    input  logic      lsu_rd_wr_req_i,
    input  logic      lsu_is_load_i,
    input  logic      ld_busy_i,
    input  logic      ld_ack_i,
    // Writeback stage
    input  logic      wrb_valid_i,
    input  reg_addr_t wrb_rd_i,
    input  logic      wrb_rd_wr_req_i,
    // To execute and the stage registers
    output fwd_sel_e  fwd_rs1_sel_o,
    output fwd_sel_e  fwd_rs2_sel_o,
    output logic      if_id_stall_o,
    output logic      lsu_stall_o,
    output logic      dec_flush_o,
    output logic      exe_flush_o
);

    logic rs1_valid;
    logic rs2_valid;
    logic lsu_rs1_hit;
    logic lsu_rs2_hit;
    logic wrb_rs1_hit;
    logic wrb_rs2_hit;
    logic ld_use_hazard;
    logic ld_stall;
    logic ld_stall_q;
    logic ld_stall_next;
    logic if_id_stall;

    // Register zero never carries a dependency
    assign rs1_valid = |exe_rs1_i;
    assign rs2_valid = |exe_rs2_i;

    ////////////////////
    // RAW detection
    ////////////////////

    assign lsu_rs1_hit = exe_valid_i & lsu_valid_i & lsu_rd_wr_req_i
                       & (exe_rs1_i == lsu_rd_i) & rs1_valid;
    assign lsu_rs2_hit = exe_valid_i & lsu_valid_i & lsu_rd_wr_req_i
                       & (exe_rs2_i == lsu_rd_i) & rs2_valid;
    assign wrb_rs1_hit = exe_valid_i & wrb_valid_i & wrb_rd_wr_req_i
                       & (exe_rs1_i == wrb_rd_i) & rs1_valid;
    assign wrb_rs2_hit = exe_valid_i & wrb_valid_i & wrb_rd_wr_req_i
                       & (exe_rs2_i == wrb_rd_i) & rs2_valid;

    // Youngest producer first; a load in LSU has no data yet
    function automatic fwd_sel_e pick_src(input logic lsu_hit, input logic wrb_hit);
        fwd_sel_e sel;
        if (lsu_hit && !lsu_is_load_i) begin
            sel = FWD_LSU;
        end else if (wrb_hit) begin
            sel = FWD_WRB;
        end else begin
            sel = FWD_NONE;
        end
        return sel;
    endfunction

    assign fwd_rs1_sel_o = pick_src(lsu_rs1_hit, wrb_rs1_hit);
    assign fwd_rs2_sel_o = pick_src(lsu_rs2_hit, wrb_rs2_hit);

    ////////////////////
    // Load stall
    ////////////////////

    // Pending load is tracked until its acknowledge
    always_comb begin
        if (ld_ack_i) begin
            ld_stall_next = 1'b0;
        end else if (ld_busy_i) begin
            ld_stall_next = 1'b1;
        end else begin
            ld_stall_next = ld_stall_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ld_stall_q <= 1'b0;
        end else begin
            ld_stall_q <= ld_stall_next;
        end
    end

    assign ld_stall = ld_stall_next;

    // Load-use, data arrives via writeback one cycle later
    assign ld_use_hazard = ((lsu_rs1_hit & exe_use_rs1_i) | (lsu_rs2_hit & exe_use_rs2_i))
                         & lsu_is_load_i & ~ld_stall;

    // Stall and flush outputs
    assign if_id_stall   = ld_stall | ld_use_hazard;
    assign if_id_stall_o = if_id_stall;
    assign lsu_stall_o   = ld_stall;
    assign exe_flush_o   = ld_use_hazard;
    // Branch acts only once its operands are final
    assign dec_flush_o   = exe_valid_i & exe_branch_taken_i & ~if_id_stall;

    // A stalled execute instruction is held, so no flush may drop it
    exe_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        (exe_valid_i && if_id_stall_o) |=> exe_valid_i);

    // Once a load is pending, the LSU keeps it until the acknowledge
    pending_load_a: assert property (@(posedge clk) disable iff (!rst_n)
        ld_stall_q |-> (ld_busy_i || ld_ack_i));

endmodule : forward_stall

//--- hdl/hazard_pipe_top.sv
// Top level of the four-stage hazard pipeline, instantiate with issue, load bus and writeback ports
`timescale 1ns/1ps
`include "core_defines.svh"

module hazard_pipe_top import rv_isa_pkg::*, pipe_ctrl_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    // Issue
    input  logic      instr_valid_i,
    input  op_e       instr_op_i,
    input  reg_addr_t instr_rs1_i,
    input  reg_addr_t instr_rs2_i,
    input  reg_addr_t instr_rd_i,
    input  word_t     instr_imm_i,
    output logic      instr_ready_o,
    // Load bus
    output logic      ld_req_o,
    output word_t     ld_addr_o,
    input  logic      ld_ack_i,
    input  word_t     ld_data_i,
    // Writeback and branch
    output logic      wb_valid_o,
    output reg_addr_t wb_rd_o,
    output word_t     wb_data_o,
    output logic      branch_taken_o
);

    logic      id_valid_q;
    op_e       id_op_q;
    reg_addr_t id_rs1_q;
    reg_addr_t id_rs2_q;
    reg_addr_t id_rd_q;
    word_t     id_imm_q;
    word_t     rf_rs1_data;
    word_t     rf_rs2_data;
    id2exe_s   id_payload;
    id2exe_s   dec_in;
    id2exe_s   dec_q;
    logic      dec_valid_in;
    logic      dec_valid_q;
    logic      dec_refresh;
    exe2lsu_s  exe_out;
    exe2lsu_s  exe_q;
    logic      exe_valid_q;
    lsu2wrb_s  lsu_out;
    lsu2wrb_s  wrb_q;
    logic      wrb_valid_q;
    logic      exe_branch_taken;
    logic      ld_busy;
    logic      if_id_stall;
    logic      lsu_stall;
    logic      dec_flush;
    logic      exe_flush;
    fwd_sel_e  fwd_rs1_sel;
    fwd_sel_e  fwd_rs2_sel;

    ////////////////////
    // Decode
    ////////////////////

    assign instr_ready_o = ~if_id_stall;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_valid_q <= `CORE_VALID_RST;
        end else if (!if_id_stall) begin
            id_valid_q <= instr_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!if_id_stall) begin
            id_op_q  <= instr_op_i;
            id_rs1_q <= instr_rs1_i;
            id_rs2_q <= instr_rs2_i;
            id_rd_q  <= instr_rd_i;
            id_imm_q <= instr_imm_i;
        end
    end

    regfile u_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_addr_i (id_rs1_q),
        .rs2_addr_i (id_rs2_q),
        .rs1_data_o (rf_rs1_data),
        .rs2_data_o (rf_rs2_data),
        .wr_en_i    (wrb_valid_q & wrb_q.rd_wr_req),
        .wr_addr_i  (wrb_q.rd),
        .wr_data_i  (wrb_q.data)
    );

    // LOAD reads rs1 only, BRANCH writes nothing
    always_comb begin
        id_payload.op        = id_op_q;
        id_payload.rs1       = id_rs1_q;
        id_payload.rs2       = id_rs2_q;
        id_payload.rd        = id_rd_q;
        id_payload.imm       = id_imm_q;
        id_payload.rs1_val   = rf_rs1_data;
        id_payload.rs2_val   = rf_rs2_data;
        id_payload.use_rs1   = 1'b1;
        id_payload.use_rs2   = (id_op_q != OP_LOAD);
        id_payload.rd_wr_req = (id_op_q != OP_BRANCH);
    end

    // A held execute instruction keeps a writeback operand that is about to retire
    assign dec_refresh = if_id_stall & ((fwd_rs1_sel == FWD_WRB) | (fwd_rs2_sel == FWD_WRB));

    always_comb begin
        dec_in       = id_payload;
        dec_valid_in = id_valid_q;
        if (dec_refresh) begin
            dec_in       = dec_q;
            dec_valid_in = dec_valid_q;
            if (fwd_rs1_sel == FWD_WRB) begin
                dec_in.rs1_val = wrb_q.data;
            end
            if (fwd_rs2_sel == FWD_WRB) begin
                dec_in.rs2_val = wrb_q.data;
            end
        end
    end

    ////////////////////
    // Stages
    ////////////////////

    pipe_reg #(.payload_t(id2exe_s)) dec_reg (
        .clk     (clk),
        .rst_n   (rst_n),
        .stall_i (if_id_stall & ~dec_refresh),
        .flush_i (dec_flush),
        .valid_i (dec_valid_in),
        .data_i  (dec_in),
        .valid_o (dec_valid_q),
        .data_o  (dec_q)
    );

    exe_unit u_exe_unit (
        .exe_data_i     (dec_q),
        .fwd_rs1_sel_i  (fwd_rs1_sel),
        .fwd_rs2_sel_i  (fwd_rs2_sel),
        .lsu_result_i   (exe_q.result),
        .wrb_data_i     (wrb_q.data),
        .exe_out_o      (exe_out),
        .branch_taken_o (exe_branch_taken)
    );

    // Load-use bubble enters here
    pipe_reg #(.payload_t(exe2lsu_s)) exe_reg (
        .clk     (clk),
        .rst_n   (rst_n),
        .stall_i (lsu_stall),
        .flush_i (exe_flush),
        .valid_i (dec_valid_q),
        .data_i  (exe_out),
        .valid_o (exe_valid_q),
        .data_o  (exe_q)
    );

    lsu_unit u_lsu_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .lsu_valid_i (exe_valid_q),
        .lsu_data_i  (exe_q),
        .ld_ack_i    (ld_ack_i),
        .ld_data_i   (ld_data_i),
        .ld_req_o    (ld_req_o),
        .ld_addr_o   (ld_addr_o),
        .ld_busy_o   (ld_busy),
        .lsu_out_o   (lsu_out)
    );

    // Writeback drains while a load waits, one write per instruction
    pipe_reg #(.payload_t(lsu2wrb_s)) wrb_reg (
        .clk     (clk),
        .rst_n   (rst_n),
        .stall_i (1'b0),
        .flush_i (lsu_stall),
        .valid_i (exe_valid_q),
        .data_i  (lsu_out),
        .valid_o (wrb_valid_q),
        .data_o  (wrb_q)
    );

    forward_stall u_forward_stall (
        .clk                (clk),
        .rst_n              (rst_n),
        .exe_valid_i        (dec_valid_q),
        .exe_rs1_i          (dec_q.rs1),
        .exe_rs2_i          (dec_q.rs2),
        .exe_use_rs1_i      (dec_q.use_rs1),
        .exe_use_rs2_i      (dec_q.use_rs2),
        .exe_branch_taken_i (exe_branch_taken),
        .lsu_valid_i        (exe_valid_q),
        .lsu_rd_i           (exe_q.rd),
        .lsu_rd_wr_req_i    (exe_q.rd_wr_req),
        .lsu_is_load_i      (exe_q.is_load),
        .ld_busy_i          (ld_busy),
        .ld_ack_i           (ld_ack_i),
        .wrb_valid_i        (wrb_valid_q),
        .wrb_rd_i           (wrb_q.rd),
        .wrb_rd_wr_req_i    (wrb_q.rd_wr_req),
        .fwd_rs1_sel_o      (fwd_rs1_sel),
        .fwd_rs2_sel_o      (fwd_rs2_sel),
        .if_id_stall_o      (if_id_stall),
        .lsu_stall_o        (lsu_stall),
        .dec_flush_o        (dec_flush),
        .exe_flush_o        (exe_flush)
    );

    // Register zero writes show up here too
    assign wb_valid_o     = wrb_valid_q & wrb_q.rd_wr_req;
    assign wb_rd_o        = wrb_q.rd;
    assign wb_data_o      = wrb_q.data;
    assign branch_taken_o = dec_flush;

endmodule : hazard_pipe_top

//--- hdl/lsu_unit.sv
// Load/store stage: load bus master, passes ADD results through to writeback
`timescale 1ns/1ps

module lsu_unit import rv_isa_pkg::*, pipe_ctrl_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     lsu_valid_i,
    input  exe2lsu_s lsu_data_i,
    input  logic     ld_ack_i,
    input  word_t    ld_data_i,
    output logic     ld_req_o,
    output word_t    ld_addr_o,
    output logic     ld_busy_o,
    output lsu2wrb_s lsu_out_o
);

    logic ld_req;

    // Request level lasts while the load sits here
    // The stage is held by control until the acknowledge edge
    assign ld_req    = lsu_valid_i & lsu_data_i.is_load;
    assign ld_req_o  = ld_req;
    assign ld_addr_o = lsu_data_i.result;

    // Same-cycle acknowledge means no wait at all
    assign ld_busy_o = ld_req & ~ld_ack_i;

    // Loaded word replaces the address, taken by the writeback register on the ack edge
    always_comb begin
        lsu_out_o.rd        = lsu_data_i.rd;
        lsu_out_o.rd_wr_req = lsu_data_i.rd_wr_req;
        if (lsu_data_i.op == OP_LOAD) begin
            lsu_out_o.data = ld_data_i;
        end else begin
            lsu_out_o.data = lsu_data_i.result;
        end
    end

    ////////////////////
    // Bus protocol
    ////////////////////

    // Request and address hold until acknowledged, which needs the stall from control
    ld_addr_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
        (ld_req_o && !ld_ack_i) |=> (ld_req_o && $stable(ld_addr_o)));

endmodule : lsu_unit

//--- hdl/pipe_ctrl_pkg.sv
// Stage payloads and forwarding selects passed between stages and control; import with pipe_ctrl_pkg::*
package pipe_ctrl_pkg;

    import rv_isa_pkg::*;

    // Where an execute operand comes from
    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,  // value read at decode
        FWD_LSU  = 2'd1,
        FWD_WRB  = 2'd2
    } fwd_sel_e;

    // Decode to execute
    typedef struct packed {
        op_e       op;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     imm;
        word_t     rs1_val;
        word_t     rs2_val;
        logic      use_rs1;
        logic      use_rs2;
        logic      rd_wr_req;
    } id2exe_s;

    // Execute to load/store, result holds the load address for OP_LOAD
    typedef struct packed {
        op_e       op;
        reg_addr_t rd;
        logic      rd_wr_req;
        word_t     result;
        logic      is_load;
    } exe2lsu_s;

    // Load/store to writeback
    typedef struct packed {
        reg_addr_t rd;
        logic      rd_wr_req;
        word_t     data;
    } lsu2wrb_s;

endpackage : pipe_ctrl_pkg

//--- hdl/pipe_reg.sv
// Pipeline stage register for any payload type, one instance per stage boundary
`timescale 1ns/1ps
`include "core_defines.svh"

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall_i,
    input  logic     flush_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    logic     valid_q;
    payload_t data_q;

    // Flush wins over stall, so a held stage can still be turned into a bubble
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= `CORE_VALID_RST;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (!stall_i) begin
            valid_q <= valid_i;
        end
    end

    // Payload only moves when the stage advances
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            data_q <= data_i;
        end
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

    // Downstream hazard logic relies on a known valid bit
    valid_known_a: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(valid_o));

endmodule : pipe_reg

//--- hdl/regfile.sv
// Integer register file read in decode and written from writeback
`timescale 1ns/1ps
`include "core_defines.svh"

module regfile import rv_isa_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    output word_t     rs1_data_o,
    output word_t     rs2_data_o,
    input  logic      wr_en_i,
    input  reg_addr_t wr_addr_i,
    input  word_t     wr_data_i
);

    word_t regs_q [`CORE_NREGS];

    // Write port, register zero never takes a value
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CORE_NREGS; i++) begin
                regs_q[i] <= `CORE_REG_RST;
            end
        end else if (wr_en_i && (wr_addr_i != '0)) begin
            regs_q[wr_addr_i] <= wr_data_i;
        end
    end

    // Shared by both read ports
    // Write-first, so decode sees the value retiring in the same cycle
    function automatic word_t read_port(input reg_addr_t addr);
        word_t rd_val;
        if (addr == '0) begin
            rd_val = '0;
        end else if (wr_en_i && (wr_addr_i == addr)) begin
            rd_val = wr_data_i;
        end else begin
            rd_val = regs_q[addr];
        end
        return rd_val;
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_addr_i);
        rs2_data_o = read_port(rs2_addr_i);
    end

endmodule : regfile

//--- hdl/rv_isa_pkg.sv
// Instruction-level types shared by decode, the stages and control; import with rv_isa_pkg::*
`include "core_defines.svh"

package rv_isa_pkg;

    ////////////////////
    // Operand types
    ////////////////////

    // Source or destination register number
    typedef logic [`CORE_RADDR_W-1:0] reg_addr_t;

    // One data word, also used for immediates and load addresses
    typedef logic [`CORE_XLEN-1:0] word_t;

    ////////////////////
    // Operations
    ////////////////////

    // Encoding follows the issue port of the top level
    typedef enum logic [1:0] {
        // rd = rs1 + rs2 + imm
        OP_ADD    = 2'd0,
        // rd = mem[rs1 + imm] over the load bus
        OP_LOAD   = 2'd1,
        // Squash the younger instruction in decode when rs1 == rs2
        OP_BRANCH = 2'd2
    } op_e;

endpackage : rv_isa_pkg
